/* flist.f */
+incdir+verification
hdl/addrgen_pkg.sv
hdl/addrgen_cfg_regs.sv
hdl/addrgen_stream.sv
hdl/addrgen_port_arbiter.sv
hdl/addrgen_bank_top.sv
verification/addrgen_bank_properties.sv
verification/addrgen_bank_tb.sv

/* hdl/addrgen_bank_top.sv */
`timescale 1ns/1ps
`default_nettype none

module addrgen_bank_top #(
  parameter int unsigned NUM_STREAMS = 4,
  parameter int unsigned CNT_W       = 10
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  // configuration writes
  input  logic                               cfg_we_i,
  input  logic [((NUM_STREAMS > 1) ? $clog2(NUM_STREAMS) : 1)-1:0] cfg_stream_i,
  input  addrgen_pkg::cfg_reg_e              cfg_reg_i,
  input  addrgen_pkg::cfg_word_u             cfg_wdata_i,
  // per-stream request levels
  input  logic [NUM_STREAMS-1:0]             req_i,
  output logic [NUM_STREAMS-1:0]             busy_o,
  output logic [NUM_STREAMS-1:0]             grant_o,
  // memory request port
  output logic                               port_valid_o,
  output logic [addrgen_pkg::ADDR_W-1:0]     port_addr_o,
  output logic [addrgen_pkg::STRB_W-1:0]     port_strb_o,
  output logic [((NUM_STREAMS > 1) ? $clog2(NUM_STREAMS) : 1)-1:0] port_sid_o
);

  logic [NUM_STREAMS-1:0][addrgen_pkg::ADDR_W-1:0]        base;
  logic signed [NUM_STREAMS-1:0][addrgen_pkg::HALF_W-1:0] line_stride;
  logic signed [NUM_STREAMS-1:0][addrgen_pkg::HALF_W-1:0] feat_stride;
  logic [NUM_STREAMS-1:0][addrgen_pkg::HALF_W-1:0]        line_len;
  logic [NUM_STREAMS-1:0][addrgen_pkg::HALF_W-1:0]        line_cnt;
  logic [NUM_STREAMS-1:0][addrgen_pkg::HALF_W-1:0]        feat_cnt;
  logic [NUM_STREAMS-1:0]                                 launch;
  logic [NUM_STREAMS-1:0][addrgen_pkg::ADDR_W-1:0]        stream_addr;
  logic [NUM_STREAMS-1:0][addrgen_pkg::STRB_W-1:0]        stream_strb;

  addrgen_cfg_regs #(
    .NUM_STREAMS (NUM_STREAMS)
  ) cfg_regs_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cfg_we_i      (cfg_we_i),
    .cfg_stream_i  (cfg_stream_i),
    .cfg_reg_i     (cfg_reg_i),
    .cfg_wdata_i   (cfg_wdata_i),
    .base_o        (base),
    .line_stride_o (line_stride),
    .feat_stride_o (feat_stride),
    .line_len_o    (line_len),
    .line_cnt_o    (line_cnt),
    .feat_cnt_o    (feat_cnt),
    .launch_o      (launch)
  );

  // one generator per stream
  for (genvar g = 0; g < NUM_STREAMS; g++) begin : gen_stream
    addrgen_stream #(
      .CNT_W (CNT_W)
    ) stream_i (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .launch_i      (launch[g]),
      .base_i        (base[g]),
      .line_stride_i (line_stride[g]),
      .feat_stride_i (feat_stride[g]),
      .line_len_i    (line_len[g]),
      .line_cnt_i    (line_cnt[g]),
      .feat_cnt_i    (feat_cnt[g]),
      .grant_i       (grant_o[g]),
      .busy_o        (busy_o[g]),
      .addr_o        (stream_addr[g]),
      .strb_o        (stream_strb[g])
    );
  end

  addrgen_port_arbiter #(
    .NUM_STREAMS (NUM_STREAMS)
  ) port_arbiter_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .busy_i       (busy_o),
    .addr_i       (stream_addr),
    .strb_i       (stream_strb),
    .grant_o      (grant_o),
    .port_valid_o (port_valid_o),
    .port_addr_o  (port_addr_o),
    .port_strb_o  (port_strb_o),
    .port_sid_o   (port_sid_o)
  );

endmodule

`default_nettype wire

/* hdl/addrgen_cfg_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module addrgen_cfg_regs #(
  parameter int unsigned NUM_STREAMS = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // config write port
  input  logic                       cfg_we_i,
  input  logic [((NUM_STREAMS > 1) ? $clog2(NUM_STREAMS) : 1)-1:0] cfg_stream_i,
  input  addrgen_pkg::cfg_reg_e      cfg_reg_i,
  input  addrgen_pkg::cfg_word_u     cfg_wdata_i,
  // decoded per-stream parameters
  output logic [NUM_STREAMS-1:0][addrgen_pkg::ADDR_W-1:0]        base_o,
  output logic signed [NUM_STREAMS-1:0][addrgen_pkg::HALF_W-1:0] line_stride_o,
  output logic signed [NUM_STREAMS-1:0][addrgen_pkg::HALF_W-1:0] feat_stride_o,
  output logic [NUM_STREAMS-1:0][addrgen_pkg::HALF_W-1:0]        line_len_o,
  output logic [NUM_STREAMS-1:0][addrgen_pkg::HALF_W-1:0]        line_cnt_o,
  output logic [NUM_STREAMS-1:0][addrgen_pkg::HALF_W-1:0]        feat_cnt_o,
  output logic [NUM_STREAMS-1:0]                                 launch_o
);

  logic [NUM_STREAMS-1:0] wr_sel;  // one-hot target stream
  logic                   launch_wr;

  // out of range indices shift the one out and select nothing
  assign wr_sel    = cfg_we_i ? (NUM_STREAMS'(1) << cfg_stream_i) : '0;
  assign launch_wr = (cfg_reg_i == addrgen_pkg::REG_LAUNCH);

  // parameter registers
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NUM_STREAMS; i++) begin
      if (wr_sel[i]) begin
        case (cfg_reg_i)
          addrgen_pkg::REG_BASE: begin
            base_o[i] <= cfg_wdata_i.addr;  // full word view
          end
          addrgen_pkg::REG_STRIDES: begin
            line_stride_o[i] <= cfg_wdata_i.halves.hi;
            feat_stride_o[i] <= cfg_wdata_i.halves.lo;
          end
          addrgen_pkg::REG_LENGTHS: begin
            line_len_o[i] <= cfg_wdata_i.halves.hi;
            line_cnt_o[i] <= cfg_wdata_i.halves.lo;
          end
          addrgen_pkg::REG_LAUNCH: begin
            feat_cnt_o[i] <= cfg_wdata_i.halves.lo;  // hi half unused
          end
          default: ;
        endcase
      end
    end
  end

  // launch strobe, one cycle after the write
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      launch_o <= '0;
    end else begin
      launch_o <= launch_wr ? wr_sel : '0;
    end
  end

endmodule

`default_nettype wire

/* hdl/addrgen_pkg.sv */
`default_nettype none

package addrgen_pkg;

  // datapath widths
  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned STRB_W     = 4;   // one bit per byte of a word
  localparam int unsigned WORD_BYTES = 4;   // address step between words
  localparam int unsigned HALF_W     = 16;  // width of one half of a config word

  // byte offset bits inside one word
  localparam int unsigned BYTE_OFF_W = $clog2(WORD_BYTES);

  // per-stream register map
  typedef enum logic [1:0] {
    REG_BASE    = 2'd0,  // base address
    REG_STRIDES = 2'd1,  // hi: line stride, lo: feature stride
    REG_LENGTHS = 2'd2,  // hi: words per line, lo: lines per feature
    REG_LAUNCH  = 2'd3   // lo: feature count, write starts the stream
  } cfg_reg_e;

  typedef struct packed {
    logic [HALF_W-1:0] hi;
    logic [HALF_W-1:0] lo;
  } cfg_halves_t;

  // one write word, read either as an address or as two halves
  typedef union packed {
    logic [ADDR_W-1:0] addr;
    cfg_halves_t       halves;
  } cfg_word_u;

endpackage

`default_nettype wire

/* hdl/addrgen_port_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module addrgen_port_arbiter #(
  parameter int unsigned NUM_STREAMS = 4
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic [NUM_STREAMS-1:0]                        req_i,
  input  logic [NUM_STREAMS-1:0]                        busy_i,
  input  logic [NUM_STREAMS-1:0][addrgen_pkg::ADDR_W-1:0] addr_i,
  input  logic [NUM_STREAMS-1:0][addrgen_pkg::STRB_W-1:0] strb_i,
  output logic [NUM_STREAMS-1:0]                        grant_o,
  // memory request port
  output logic                                          port_valid_o,
  output logic [addrgen_pkg::ADDR_W-1:0]                port_addr_o,
  output logic [addrgen_pkg::STRB_W-1:0]                port_strb_o,
  output logic [((NUM_STREAMS > 1) ? $clog2(NUM_STREAMS) : 1)-1:0] port_sid_o
);

  localparam int unsigned SID_W = (NUM_STREAMS > 1) ? $clog2(NUM_STREAMS) : 1;

  logic [NUM_STREAMS-1:0]         cand;
  logic [addrgen_pkg::ADDR_W-1:0] sel_addr;
  logic [addrgen_pkg::STRB_W-1:0] sel_strb;
  logic [SID_W-1:0]               sel_sid;

  assign cand    = req_i & busy_i;
  assign grant_o = cand & (~cand + 1'b1);  // isolate lowest set bit

  // one-hot select of the winner
  always_comb begin
    sel_addr = '0;
    sel_strb = '0;
    sel_sid  = '0;
    for (int i = 0; i < NUM_STREAMS; i++) begin
      if (grant_o[i]) begin
        sel_addr = addr_i[i];
        sel_strb = strb_i[i];
        sel_sid  = SID_W'(i);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      port_valid_o <= 1'b0;
      port_addr_o  <= '0;
      port_strb_o  <= '0;
      port_sid_o   <= '0;
    end else begin
      port_valid_o <= |grant_o;
      if (|grant_o) begin
        // hold last word while idle
        port_addr_o <= sel_addr;
        port_strb_o <= sel_strb;
        port_sid_o  <= sel_sid;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/addrgen_stream.sv */
`timescale 1ns/1ps
`default_nettype none

module addrgen_stream #(
  parameter int unsigned CNT_W = 10
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 launch_i,
  // live configuration
  input  logic        [addrgen_pkg::ADDR_W-1:0] base_i,
  input  logic signed [addrgen_pkg::HALF_W-1:0] line_stride_i,
  input  logic signed [addrgen_pkg::HALF_W-1:0] feat_stride_i,
  input  logic        [addrgen_pkg::HALF_W-1:0] line_len_i,
  input  logic        [addrgen_pkg::HALF_W-1:0] line_cnt_i,
  input  logic        [addrgen_pkg::HALF_W-1:0] feat_cnt_i,
  // port side
  input  logic                                 grant_i,
  output logic                                 busy_o,
  output logic        [addrgen_pkg::ADDR_W-1:0] addr_o,
  output logic        [addrgen_pkg::STRB_W-1:0] strb_o
);

  localparam int unsigned AW   = addrgen_pkg::ADDR_W;
  localparam int unsigned HW   = addrgen_pkg::HALF_W;
  localparam int unsigned OFFW = addrgen_pkg::BYTE_OFF_W;
  localparam int unsigned SW   = addrgen_pkg::STRB_W;

  logic             start_q;     // setup cycle after launch
  logic             misalign_q;
  logic [CNT_W-1:0] word_q;
  logic [CNT_W-1:0] line_q;
  logic [CNT_W-1:0] feat_q;
  logic [AW-1:0]    line_off_q;  // accumulated line strides
  logic [AW-1:0]    feat_off_q;  // accumulated feature strides

  logic [HW-1:0]    wpl_m1;      // words per line minus one
  logic             word_last;
  logic             line_last;
  logic             feat_last;
  logic             empty;
  logic             advance;
  logic [AW-1:0]    line_start;
  logic [AW-1:0]    word_base;
  logic [OFFW-1:0]  byte_off;
  logic [SW-1:0]    head_strb;

  // misaligned lines carry one extra word
  assign wpl_m1    = misalign_q ? line_len_i : line_len_i - 1'b1;
  assign word_last = (HW'(word_q) == wpl_m1);
  assign line_last = (HW'(line_q) == line_cnt_i - 1'b1);
  assign feat_last = (HW'(feat_q) == feat_cnt_i - 1'b1);

  // nothing to walk if any loop has zero trips
  assign empty   = (line_len_i == '0) || (line_cnt_i == '0) || (feat_cnt_i == '0);
  assign advance = grant_i & busy_o;

  // address of the current word
  assign line_start = base_i + feat_off_q + line_off_q;
  assign byte_off   = line_start[OFFW-1:0];
  assign word_base  = {line_start[AW-1:OFFW], {OFFW{1'b0}}};
  assign addr_o     = word_base + AW'(word_q) * addrgen_pkg::WORD_BYTES;

  // byte strobes
  always_comb begin
    head_strb = {SW{1'b1}} << byte_off;
    strb_o    = {SW{1'b1}};
    if (misalign_q) begin
      if (word_q == '0) begin
        strb_o = head_strb;   // bytes from the line start on
      end else if (word_last) begin
        strb_o = ~head_strb;  // tail bytes, zero for aligned line starts
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_q    <= 1'b0;
      busy_o     <= 1'b0;
      misalign_q <= 1'b0;
      word_q     <= '0;
      line_q     <= '0;
      feat_q     <= '0;
      line_off_q <= '0;
      feat_off_q <= '0;
    end else if (launch_i) begin
      // also aborts a walk in progress
      start_q    <= 1'b1;
      busy_o     <= 1'b0;
      misalign_q <= (base_i[OFFW-1:0] != '0) ||
                    (line_stride_i[OFFW-1:0] != '0) ||
                    (feat_stride_i[OFFW-1:0] != '0);
      word_q     <= '0;
      line_q     <= '0;
      feat_q     <= '0;
      line_off_q <= '0;
      feat_off_q <= '0;
    end else if (start_q) begin
      start_q <= 1'b0;
      busy_o  <= !empty;
    end else if (advance) begin
      if (!word_last) begin
        word_q <= word_q + 1'b1;
      end else begin
        word_q <= '0;
        if (!line_last) begin
          line_q     <= line_q + 1'b1;
          line_off_q <= line_off_q + AW'(line_stride_i);  // sign extended
        end else begin
          line_q     <= '0;
          line_off_q <= '0;
          if (!feat_last) begin
            feat_q     <= feat_q + 1'b1;
            feat_off_q <= feat_off_q + AW'(feat_stride_i);
          end else begin
            // last word granted
            feat_q     <= '0;
            feat_off_q <= '0;
            busy_o     <= 1'b0;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the address generator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module addrgen_bank_tb -Mdir obj_dir -f flist.f

# keep running after assertion errors so the testbench prints its verdict
out=$(./obj_dir/Vaddrgen_bank_tb +verilator+error+limit+1000) || true
echo "$out"

if grep -qx "all tests passed" <<< "$out"; then
  exit 0
fi
exit 1

/* verification/addrgen_bank_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module addrgen_bank_properties #(
  parameter int unsigned NUM_STREAMS = 4
) (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic [NUM_STREAMS-1:0] req_i,
  input logic [NUM_STREAMS-1:0] busy_i,
  input logic [NUM_STREAMS-1:0] grant_i,
  input logic                   port_valid_i
);

  // at most one winner per cycle
  grant_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(grant_i))
    else $error("grant is neither one-hot nor zero");

  grant_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (grant_i & ~(req_i & busy_i)) == '0)
    else $error("grant to a stream that is idle or not requesting");

  // registered port, one cycle behind the grant
  valid_after_grant: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (|grant_i) |=> port_valid_i)
    else $error("no port word one cycle after a grant");

  no_valid_without_grant: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(|grant_i) |=> !port_valid_i)
    else $error("port word without a grant in the cycle before");

endmodule

`default_nettype wire

/* verification/addrgen_model.svh */
`ifndef ADDRGEN_MODEL_SVH
`define ADDRGEN_MODEL_SVH

// expected port words per stream, {strb, addr}
logic [addrgen_pkg::STRB_W+addrgen_pkg::ADDR_W-1:0] exp_q [NUM_STREAMS][$];

// walk of one stream, replaces whatever was still pending
function automatic void build_walk(input int sid, input logic [31:0] base,
                                   input logic [15:0] lstride, input logic [15:0] fstride,
                                   input int llen, input int lcnt, input int fcnt);
  logic [31:0] ls32;
  logic [31:0] fs32;
  logic [31:0] lstart;
  logic [3:0]  head;
  logic [3:0]  strb;
  bit          mis;
  int          wpl;
  exp_q[sid].delete();
  ls32 = {{16{lstride[15]}}, lstride};  // signed strides
  fs32 = {{16{fstride[15]}}, fstride};
  mis  = (base[1:0] != 2'b00) || (lstride[1:0] != 2'b00) || (fstride[1:0] != 2'b00);
  wpl  = mis ? llen + 1 : llen;
  if (llen == 0 || lcnt == 0 || fcnt == 0) return;
  for (int f = 0; f < fcnt; f++) begin
    for (int l = 0; l < lcnt; l++) begin
      lstart = base + 32'(f) * fs32 + 32'(l) * ls32;
      head   = 4'hf << lstart[1:0];
      for (int k = 0; k < wpl; k++) begin
        strb = 4'hf;
        if (mis && k == 0) strb = head;
        else if (mis && k == wpl - 1) strb = ~head;  // zero when the line starts aligned
        exp_q[sid].push_back({strb, {lstart[31:2], 2'b00} + 32'(4 * k)});
      end
    end
  end
endfunction

// fixed priority, lowest busy requesting index wins
function automatic logic [NUM_STREAMS-1:0] lowest_grant(input logic [NUM_STREAMS-1:0] r,
                                                        input logic [NUM_STREAMS-1:0] b);
  logic [NUM_STREAMS-1:0] g;
  g = '0;
  for (int i = NUM_STREAMS - 1; i >= 0; i--) begin
    if (r[i] && b[i]) g = NUM_STREAMS'(1) << i;
  end
  return g;
endfunction

function automatic bit queues_empty();
  for (int i = 0; i < NUM_STREAMS; i++) begin
    if (exp_q[i].size() != 0) return 1'b0;
  end
  return 1'b1;
endfunction

`endif

/* verification/addrgen_bank_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module addrgen_bank_tb;

  localparam int unsigned NUM_STREAMS = 4;
  localparam int unsigned SID_W       = 2;

  logic                           clk;
  logic                           rst_n;
  logic                           cfg_we;
  logic [SID_W-1:0]               cfg_stream;
  addrgen_pkg::cfg_reg_e          cfg_reg;
  addrgen_pkg::cfg_word_u         cfg_wdata;
  logic [NUM_STREAMS-1:0]         req;
  logic [NUM_STREAMS-1:0]         busy;
  logic [NUM_STREAMS-1:0]         grant;
  logic                           port_valid;
  logic [addrgen_pkg::ADDR_W-1:0] port_addr;
  logic [addrgen_pkg::STRB_W-1:0] port_strb;
  logic [SID_W-1:0]               port_sid;

  int                     cycle_cnt   = 0;
  int                     cycle_limit = 300;
  int                     err_cnt     = 0;
  int                     test_errs   = 0;
  int                     tests_run   = 0;
  int                     tests_bad   = 0;
  int                     flush_cyc [NUM_STREAMS];  // first cycle whose port word is compared
  logic [NUM_STREAMS-1:0] prev_grant  = '0;

  `include "addrgen_model.svh"

  addrgen_bank_top #(
    .NUM_STREAMS (NUM_STREAMS),
    .CNT_W       (10)
  ) dut_i (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .cfg_we_i     (cfg_we),
    .cfg_stream_i (cfg_stream),
    .cfg_reg_i    (cfg_reg),
    .cfg_wdata_i  (cfg_wdata),
    .req_i        (req),
    .busy_o       (busy),
    .grant_o      (grant),
    .port_valid_o (port_valid),
    .port_addr_o  (port_addr),
    .port_strb_o  (port_strb),
    .port_sid_o   (port_sid)
  );

  bind addrgen_port_arbiter addrgen_bank_properties #(
    .NUM_STREAMS (NUM_STREAMS)
  ) properties_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .busy_i       (busy_i),
    .grant_i      (grant_o),
    .port_valid_i (port_valid_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout: the walks did not finish by cycle %0d", cycle_limit);
      $display("tests failed");
      $finish;
    end
  end

  function automatic void flag_error(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    err_cnt++;
  endfunction

  // grant and port checks, away from the clock edge
  always @(negedge clk) begin
    logic [35:0] exp_w;
    int          sid;
    if (rst_n) begin
      assert (grant == lowest_grant(req, busy))
        else flag_error($sformatf("grant %b for req %b busy %b", grant, req, busy));
      assert (port_valid == (prev_grant != '0))
        else flag_error($sformatf("port valid %b after grant %b", port_valid, prev_grant));
      if (port_valid) begin
        sid = int'(port_sid);
        assert (prev_grant[sid]) else flag_error($sformatf("port sid %0d not granted", sid));
        if (cycle_cnt >= flush_cyc[sid]) begin
          if (exp_q[sid].size() == 0) begin
            flag_error($sformatf("stream %0d sent a word after its walk ended", sid));
          end else begin
            exp_w = exp_q[sid].pop_front();
            assert ({port_strb, port_addr} == exp_w)
              else flag_error($sformatf("stream %0d got strb %h addr %h, expected %h %h",
                                        sid, port_strb, port_addr, exp_w[35:32], exp_w[31:0]));
          end
        end
      end
      for (int i = 0; i < NUM_STREAMS; i++) begin
        // busy from two edges after the launch pulse until the last grant
        if (cycle_cnt >= flush_cyc[i] - 1) begin
          assert (busy[i] == (exp_q[i].size() != 0))
            else flag_error($sformatf("stream %0d busy %b, expected %b", i, busy[i],
                                      exp_q[i].size() != 0));
        end
      end
    end
    prev_grant = grant;
  end

  task automatic write_cfg(input int sid, input addrgen_pkg::cfg_reg_e r,
                           input addrgen_pkg::cfg_word_u w);
    @(posedge clk);
    #2;
    cfg_we     = 1'b1;
    cfg_stream = SID_W'(sid);
    cfg_reg    = r;
    cfg_wdata  = w;
    // pulse one cycle after the write, new words granted two cycles later
    if (r == addrgen_pkg::REG_LAUNCH) flush_cyc[sid] = cycle_cnt + 4;
    @(posedge clk);
    #2;
    cfg_we = 1'b0;
  endtask

  task automatic start_walk(input int sid, input logic [31:0] base, input logic [15:0] ls,
                            input logic [15:0] fs, input int llen, input int lcnt,
                            input int fcnt, input bit full);
    addrgen_pkg::cfg_word_u w;
    if (full) begin
      w.addr = base;
      write_cfg(sid, addrgen_pkg::REG_BASE, w);
      w.halves.hi = ls;
      w.halves.lo = fs;
      write_cfg(sid, addrgen_pkg::REG_STRIDES, w);
      w.halves.hi = 16'(llen);
      w.halves.lo = 16'(lcnt);
      write_cfg(sid, addrgen_pkg::REG_LENGTHS, w);
    end
    w.halves.hi = '0;
    w.halves.lo = 16'(fcnt);
    write_cfg(sid, addrgen_pkg::REG_LAUNCH, w);
    build_walk(sid, base, ls, fs, llen, lcnt, fcnt);
    cycle_limit += 2 * exp_q[sid].size();
  endtask

  task automatic wait_idle(input bit rand_req);
    bit idle;
    do begin
      @(posedge clk);
      #2;
      if (rand_req) req = NUM_STREAMS'($urandom) | NUM_STREAMS'($urandom);  // mostly high
      idle = (busy == '0) && !port_valid && queues_empty();
    end while (!idle);
  endtask

  task automatic begin_test();
    test_errs   = err_cnt;
    cycle_limit = cycle_cnt + 200;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (err_cnt != test_errs) begin
      tests_bad++;
      $display("%s: FAIL with %0d errors", name, err_cnt - test_errs);
    end else begin
      $display("%s: ok", name);
    end
  endtask

  initial begin
    int          sid;
    int          off;
    logic [31:0] base;
    logic [15:0] ls;
    logic [15:0] fs;
    void'($urandom(32'h3a3694b6));
    rst_n      = 1'b0;
    cfg_we     = 1'b0;
    cfg_stream = '0;
    cfg_reg    = addrgen_pkg::REG_BASE;
    cfg_wdata  = '0;
    req        = '0;
    for (int i = 0; i < NUM_STREAMS; i++) flush_cyc[i] = 0;
    repeat (10) @(posedge clk);
    #2;
    assert (busy == '0 && grant == '0 && !port_valid && port_addr == '0 && port_strb == '0
            && port_sid == '0) else flag_error("outputs not at their reset values");
    rst_n = 1'b1;

    begin_test();
    sid = $urandom_range(0, NUM_STREAMS - 1);
    req = '1;
    start_walk(sid, $urandom & ~32'h3, 16'(4 * $urandom_range(1, 64)),
               16'(4 * $urandom_range(1, 512)), $urandom_range(1, 4), $urandom_range(1, 4),
               $urandom_range(1, 3), 1'b1);
    wait_idle(1'b0);
    end_test("aligned walk");

    begin_test();
    sid = $urandom_range(0, NUM_STREAMS - 1);
    off = $urandom_range(1, 3);
    // second line of the first feature starts on a word boundary
    start_walk(sid, ($urandom & ~32'h3) | 32'(off), 16'(4 * $urandom_range(1, 64) + 4 - off),
               16'($urandom_range(0, 4000)), $urandom_range(1, 4), $urandom_range(2, 4),
               $urandom_range(1, 3), 1'b1);
    wait_idle(1'b0);
    end_test("misaligned walk");

    begin_test();
    sid = $urandom_range(0, NUM_STREAMS - 1);
    start_walk(sid, 32'($urandom_range(0, 255)), 16'(-$urandom_range(1, 400)),
               16'(-$urandom_range(1, 2000)), $urandom_range(1, 4), $urandom_range(1, 4),
               $urandom_range(1, 3), 1'b1);
    wait_idle(1'b0);
    end_test("negative strides");

    begin_test();
    req = NUM_STREAMS'($urandom);
    for (int i = 0; i < NUM_STREAMS; i++) begin
      start_walk(i, $urandom, 16'($urandom), 16'($urandom), $urandom_range(1, 4),
                 $urandom_range(1, 4), $urandom_range(1, 3), 1'b1);
    end
    wait_idle(1'b1);
    end_test("concurrent streams");

    begin_test();
    sid  = $urandom_range(0, NUM_STREAMS - 1);
    req  = '1;
    base = $urandom;
    ls   = 16'($urandom);
    fs   = 16'($urandom);
    start_walk(sid, base, ls, fs, 4, 4, 3, 1'b1);
    repeat ($urandom_range(5, 25)) @(posedge clk);
    start_walk(sid, base, ls, fs, 4, 4, $urandom_range(1, 2), 1'b0);  // launch register only
    wait_idle(1'b0);
    end_test("relaunch");

    $display("summary: %0d run, %0d passed, %0d failed, %0d errors",
             tests_run, tests_run - tests_bad, tests_bad, err_cnt);
    if (err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
